// ==== hw/msx_types_pkg.sv ====
package msx_types_pkg;

   typedef enum logic [7:0] {
      mapper_unused     = 8'd0,
      mapper_offset     = 8'd1,
      mapper_ascii8     = 8'd2,
      mapper_ascii16    = 8'd3,
      mapper_konami     = 8'd4,
      mapper_konami_scc = 8'd5,
      mapper_ram        = 8'd6
   } mapper_t;

   typedef enum logic [7:0] {
      device_none   = 8'd0,
      device_fm_pac = 8'd1,
      device_scc    = 8'd2,
      device_scc2   = 8'd3,
      device_opl3   = 8'd4
   } device_t;

   typedef enum logic [1:0] {msx1, msx2, msx2p, msx_tr} msx_typ_t;

   typedef struct packed {
      mapper_t    mapper;
      device_t    device;
      logic [3:0] ref_ram;      // Index into the lookup table
      logic [1:0] offset_ram;   // 16 KB page inside the block
   } slot_entry_t;

   typedef slot_entry_t [3:0] slot_row_t;

   typedef struct packed {
      logic [26:0] addr;
      logic [15:0] size;        // In 16 KB units
      logic        ro;
   } lookup_ram_t;

   typedef struct packed {
      logic [3:0] slot_expander_en;
      msx_typ_t   msx_typ;
   } bios_config_t;

   typedef struct packed {
      logic [3:0] subslot;
      logic [7:0] mode;         // 2 bits per page
      logic [7:0] param;
      mapper_t    mapper;
      device_t    device;
      logic [3:0] ref_ram;
   } slot_cmd_t;

   typedef struct packed {
      logic        wr;
      slot_entry_t entry;
   } page_update_t;

   localparam slot_entry_t slot_entry_empty = '{
      mapper:     mapper_unused,
      device:     device_none,
      ref_ram:    4'd0,
      offset_ram: 2'd0
   };

endpackage

// ==== hw/upload_pkg.sv ====
package upload_pkg;

   localparam int ddr_addr_w   = 28;
   localparam int ram_addr_w   = 27;
   localparam int ioctl_addr_w = 27;
   localparam int len_w        = 25;      // Up to 2047 blocks of 16 KB
   localparam int header_len   = 16;
   localparam int block_shift  = 14;      // 16 KB unit
   localparam int kbd_body_len = 'h200;
   localparam int config_index = 1;

   localparam logic [ram_addr_w-1:0] ram_start = '0;
   localparam logic [23:0] record_magic = "MSX";

   // Byte positions inside a record header
   localparam int hdr_typ     = 3;        // Type high nibble, subslot low
   localparam int hdr_data_id = 4;        // BIOS config byte in config records
   localparam int hdr_size_hi = 5;
   localparam int hdr_size_lo = 6;
   localparam int hdr_device  = 7;
   localparam int hdr_mapper  = 8;
   localparam int hdr_mode    = 9;
   localparam int hdr_param   = 10;

   typedef enum logic [3:0] {
      cfg_slot_internal = 4'd3,
      cfg_kbd_layout    = 4'd4,
      cfg_config        = 4'd5
   } config_typ_t;

   typedef enum logic [7:0] {
      rom_none = 8'd0,
      rom_rom  = 8'd1,
      rom_ram  = 8'd2,
      rom_fw   = 8'd3
   } data_id_t;

endpackage

// ==== hw/page_entry_builder.sv ====
`timescale 1ns/1ps

module page_entry_builder
   import msx_types_pkg::*;
#(
   parameter int page = 0
) (
   input  slot_cmd_t    slot_cmd,
   input  slot_row_t    row,
   output page_update_t update
);

   logic [1:0]  mode;
   logic [1:0]  param;
   slot_entry_t src;

   assign mode  = slot_cmd.mode[2*page+1 -: 2];
   assign param = slot_cmd.param[2*page+1 -: 2];
   assign src   = row[param];                      // Old value before this store

   always_comb begin
      update.wr    = mode != 2'd0;
      update.entry = src;
      case (mode)
         2'd1: update.entry.device = device_none;   // Mirror of another page
         2'd2: begin
            update.entry.mapper     = slot_cmd.mapper;
            update.entry.device     = slot_cmd.device;
            update.entry.ref_ram    = slot_cmd.ref_ram;
            update.entry.offset_ram = param;
         end
         2'd3: begin
            update.entry.mapper     = mapper_unused;
            update.entry.device     = slot_cmd.device;
            update.entry.ref_ram    = slot_cmd.ref_ram;
            update.entry.offset_ram = param;
         end
         default: ;
      endcase
   end

endmodule

// ==== hw/slot_table.sv ====
`timescale 1ns/1ps

module slot_table
   import msx_types_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n,
   input  logic         slot_clear,
   input  logic         slot_store,
   input  logic [3:0]   subslot,
   input  page_update_t updates [4],
   output slot_row_t    row,
   output slot_entry_t  slot_layout [64]
);

   slot_row_t rows [16];

   assign row = rows[subslot];

   always_ff @(posedge clk) begin
      if (!rst_n || slot_clear) begin
         for (int s = 0; s < 16; s++) begin
            rows[s] <= {4{slot_entry_empty}};
         end
      end else if (slot_store) begin
         for (int p = 0; p < 4; p++) begin
            if (updates[p].wr) rows[subslot][p] <= updates[p].entry;
         end
      end
   end

   // Flat view indexed by {subslot, page}
   for (genvar s = 0; s < 16; s++) begin : g_sub
      for (genvar p = 0; p < 4; p++) begin : g_page
         assign slot_layout[s*4+p] = rows[s][p];
      end
   end

endmodule

// ==== hw/block_loader.sv ====
`timescale 1ns/1ps

module block_loader
   import upload_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  load_start,
   input  logic [ddr_addr_w-1:0] load_addr,
   input  logic [len_w-1:0]      load_len,
   input  logic                  load_pattern,
   input  logic [ram_addr_w-1:0] ram_base,
   output logic                  busy,
   output logic                  done,
   output logic [ddr_addr_w-1:0] ddr3_addr,
   output logic                  ddr3_rd,
   input  logic [7:0]            ddr3_dout,
   input  logic                  ddr3_ready,
   output logic [ram_addr_w-1:0] ram_addr,
   output logic [7:0]            ram_din,
   output logic                  ram_ce,
   output logic                  ram_rq,
   input  logic                  ram_ready
);

   typedef enum logic [1:0] {ld_idle, ld_fetch, ld_write} ld_state_t;

   ld_state_t        state;
   logic [len_w-1:0] remain;
   logic             pattern;
   logic [7:0]       data_q;

   assign busy    = state != ld_idle;
   assign ram_rq  = busy;
   assign ram_ce  = state == ld_write && ram_ready;
   assign ram_din = !pattern ? data_q :
                    (ram_addr[8] == ram_addr[1]) ? 8'hff : 8'h00;   // RAM stripe

   always_ff @(posedge clk) begin
      done <= 1'b0;
      if (!rst_n) begin
         state    <= ld_idle;
         ddr3_rd  <= 1'b0;
         ram_addr <= ram_base;
      end else begin
         case (state)
            ld_idle: if (load_start) begin
               state     <= ld_fetch;
               ddr3_addr <= load_addr;
               ddr3_rd   <= !load_pattern;
               remain    <= load_len;
               pattern   <= load_pattern;
            end
            ld_fetch: begin
               if (pattern) begin
                  state <= ld_write;
               end else if (ddr3_ready) begin
                  if (ddr3_rd) begin
                     ddr3_rd   <= 1'b0;
                     ddr3_addr <= ddr3_addr + 1'b1;
                  end else begin
                     data_q <= ddr3_dout;
                     state  <= ld_write;
                  end
               end
            end
            ld_write: if (ram_ready) begin
               ram_addr <= ram_addr + 1'b1;
               remain   <= remain - 1'b1;
               if (remain == len_w'(1)) begin
                  done  <= 1'b1;
                  state <= ld_idle;
               end else begin
                  state   <= ld_fetch;
                  ddr3_rd <= !pattern;
               end
            end
            default: state <= ld_idle;
         endcase
      end
   end

   a_ce_pulse: assert property (@(posedge clk) disable iff (!rst_n) ram_ce |=> !ram_ce);

endmodule

// ==== hw/record_sequencer.sv ====
`timescale 1ns/1ps

module record_sequencer
   import msx_types_pkg::*;
   import upload_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    load,
   input  logic [ioctl_addr_w-1:0] config_size,
   input  logic                    ddr3_ready,
   input  logic [7:0]              ddr3_dout,
   output logic [ddr_addr_w-1:0]   ddr3_addr,
   output logic                    ddr3_rd,
   output logic                    ddr3_request,
   output logic                    reset_rq,
   output logic                    load_start,
   output logic [ddr_addr_w-1:0]   load_addr,
   output logic [len_w-1:0]        load_len,
   output logic                    load_pattern,
   input  logic                    busy,
   input  logic                    done,
   output slot_cmd_t               slot_cmd,
   output logic                    slot_store,
   output logic                    slot_clear,
   output lookup_ram_t             lookup_ram [16],
   output bios_config_t            bios_config
);

   typedef enum logic [2:0] {st_idle, st_read_hdr, st_check, st_load, st_store} seq_state_t;

   seq_state_t            state;
   logic [7:0]            hdr [header_len];
   logic [4:0]            hdr_cnt;             // 0 means record start
   logic [3:0]            ref_ram;
   logic                  ref_add;
   logic [ram_addr_w-1:0] ram_next;
   config_typ_t           typ;
   data_id_t              data_id;
   logic [len_w-1:0]      blk_len;

   assign typ        = config_typ_t'(hdr[hdr_typ][7:4]);
   assign data_id    = data_id_t'(hdr[hdr_data_id]);
   assign blk_len    = len_w'({hdr[hdr_size_hi][2:0], hdr[hdr_size_lo]}) << block_shift;
   assign reset_rq   = state != st_idle;
   assign slot_clear = load;

   always_ff @(posedge clk) begin
      load_start <= 1'b0;
      slot_store <= 1'b0;
      if (!rst_n) begin
         state        <= st_idle;
         ddr3_addr    <= '0;
         ddr3_rd      <= 1'b0;
         ddr3_request <= 1'b0;
         hdr_cnt      <= '0;
         ref_ram      <= '0;
         ref_add      <= 1'b0;
         ram_next     <= ram_start;
         bios_config  <= '0;
      end else if (load) begin
         state        <= st_read_hdr;
         ddr3_addr    <= '0;
         ddr3_rd      <= 1'b0;
         ddr3_request <= 1'b1;
         hdr_cnt      <= '0;
         ref_ram      <= '0;
         ref_add      <= 1'b0;
      end else begin
         if (ddr3_ready && ddr3_rd) begin
            ddr3_rd   <= 1'b0;
            ddr3_addr <= ddr3_addr + 1'b1;
         end
         if (state == st_idle) ddr3_request <= 1'b0;
         if (state == st_load && done) state <= st_store;   // Loader may finish during a stall
         if (ddr3_ready && !ddr3_rd) begin
            case (state)
               st_read_hdr: begin
                  if (hdr_cnt == 5'd0) begin
                     if (ddr3_addr >= ddr_addr_w'(config_size)) begin
                        state <= st_idle;                   // Walked past the download
                     end else begin
                        ddr3_rd <= 1'b1;
                        hdr_cnt <= 5'd1;
                     end
                  end else begin
                     hdr[4'(hdr_cnt - 5'd1)] <= ddr3_dout;
                     if (hdr_cnt == 5'(header_len)) begin
                        state   <= st_check;
                        hdr_cnt <= '0;
                     end else begin
                        ddr3_rd <= 1'b1;
                        hdr_cnt <= hdr_cnt + 5'd1;
                     end
                  end
               end
               st_check: begin
                  state <= st_read_hdr;
                  if ({hdr[0], hdr[1], hdr[2]} != record_magic) begin
                     state <= st_idle;
                  end else begin
                     case (typ)
                        cfg_config: begin
                           bios_config.slot_expander_en <= hdr[hdr_data_id][3:0];
                           bios_config.msx_typ          <= msx_typ_t'(hdr[hdr_data_id][5:4]);
                        end
                        cfg_kbd_layout: ddr3_addr <= ddr3_addr + ddr_addr_w'(kbd_body_len);
                        cfg_slot_internal: begin
                           slot_cmd.subslot <= hdr[hdr_typ][3:0];
                           slot_cmd.mode    <= hdr[hdr_mode];
                           slot_cmd.param   <= hdr[hdr_param];
                           slot_cmd.mapper  <= mapper_t'(hdr[hdr_mapper]);
                           slot_cmd.device  <= device_t'(hdr[hdr_device]);
                           slot_cmd.ref_ram <= ref_ram;
                           if (data_id == rom_none) begin
                              state <= st_store;
                           end else begin
                              state        <= st_load;
                              load_start   <= 1'b1;
                              load_addr    <= ddr3_addr;       // Body follows the header
                              load_len     <= blk_len;
                              load_pattern <= data_id == rom_ram;
                              lookup_ram[ref_ram] <= '{
                                 addr: ram_next,
                                 size: 16'({hdr[hdr_size_hi][2:0], hdr[hdr_size_lo]}),
                                 ro:   data_id != rom_ram
                              };
                              ram_next <= ram_next + ram_addr_w'(blk_len);
                              ref_add  <= 1'b1;
                              if (data_id != rom_ram) ddr3_addr <= ddr3_addr + ddr_addr_w'(blk_len);
                           end
                        end
                        default: ;
                     endcase
                  end
               end
               st_store: begin
                  slot_store <= 1'b1;
                  ref_ram    <= ref_ram + 4'(ref_add);
                  ref_add    <= 1'b0;
                  state      <= st_read_hdr;
               end
               default: ;
            endcase
         end
      end
   end

   // Loader must be idle at start and take the block the next cycle
   a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
      load_start |-> !busy ##1 busy);

endmodule

// ==== hw/memory_upload.sv ====
`timescale 1ns/1ps

module memory_upload
   import msx_types_pkg::*;
   import upload_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    ioctl_download,
   input  logic [15:0]             ioctl_index,
   input  logic [ioctl_addr_w-1:0] ioctl_addr,
   output logic                    reset_rq,
   output logic [ddr_addr_w-1:0]   ddr3_addr,
   output logic                    ddr3_rd,
   output logic                    ddr3_request,
   input  logic [7:0]              ddr3_dout,
   input  logic                    ddr3_ready,
   output logic [ram_addr_w-1:0]   ram_addr,
   output logic [7:0]              ram_din,
   output logic                    ram_ce,
   output logic                    ram_rq,
   input  logic                    ram_ready,
   output slot_entry_t             slot_layout [64],
   output lookup_ram_t             lookup_ram [16],
   output bios_config_t            bios_config
);

   logic                    dl_last;
   logic                    cfg_end;
   logic                    load;
   logic [ioctl_addr_w-1:0] config_size;
   logic [ddr_addr_w-1:0]   seq_ddr_addr;
   logic [ddr_addr_w-1:0]   ld_ddr_addr;
   logic                    seq_ddr_rd;
   logic                    ld_ddr_rd;
   logic                    load_start;
   logic [ddr_addr_w-1:0]   load_addr;
   logic [len_w-1:0]        load_len;
   logic                    load_pattern;
   logic                    busy;
   logic                    done;
   slot_cmd_t               slot_cmd;
   logic                    slot_store;
   logic                    slot_clear;
   slot_row_t               row;
   page_update_t            updates [4];

   assign cfg_end   = dl_last && !ioctl_download && ioctl_index[5:0] == 6'(config_index);
   assign ddr3_addr = busy ? ld_ddr_addr : seq_ddr_addr;   // Loader owns DDR3 while busy
   assign ddr3_rd   = busy ? ld_ddr_rd : seq_ddr_rd;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dl_last <= 1'b0;
         load    <= 1'b0;
      end else begin
         dl_last <= ioctl_download;
         load    <= cfg_end;
      end
      if (cfg_end) config_size <= ioctl_addr;
   end

   record_sequencer u_seq (
      .clk, .rst_n, .load, .config_size, .ddr3_ready, .ddr3_dout,
      .ddr3_addr(seq_ddr_addr), .ddr3_rd(seq_ddr_rd), .ddr3_request, .reset_rq,
      .load_start, .load_addr, .load_len, .load_pattern, .busy, .done,
      .slot_cmd, .slot_store, .slot_clear, .lookup_ram, .bios_config
   );

   block_loader u_loader (
      .clk, .rst_n, .load_start, .load_addr, .load_len, .load_pattern,
      .ram_base(ram_start), .busy, .done,
      .ddr3_addr(ld_ddr_addr), .ddr3_rd(ld_ddr_rd), .ddr3_dout, .ddr3_ready,
      .ram_addr, .ram_din, .ram_ce, .ram_rq, .ram_ready
   );

   for (genvar g = 0; g < 4; g++) begin : g_page
      page_entry_builder #(.page(g)) u_page (.slot_cmd, .row, .update(updates[g]));
   end

   slot_table u_table (
      .clk, .rst_n, .slot_clear, .slot_store, .subslot(slot_cmd.subslot),
      .updates, .row, .slot_layout
   );

endmodule

// ==== verification/ddr3_model.sv ====
`timescale 1ns/1ps

module ddr3_model (
   input  logic        clk,
   input  logic        rst_n,
   input  logic [27:0] addr,
   input  logic        rd,
   input  logic [1:0]  stall,        // Ready-low cycles after each read
   output logic [7:0]  dout,
   output logic        ready
);

   logic [7:0]  mem [65536];
   logic        taken;
   logic [27:0] taken_addr;
   logic [1:0]  taken_stall;
   logic [1:0]  stall_cnt;

   always @(posedge clk) begin
      taken       <= rst_n && rd && ready;
      taken_addr  <= addr;
      taken_stall <= stall;
   end

   // Outputs change on the falling edge
   always @(negedge clk) begin
      if (!rst_n) begin
         ready     <= 1'b1;
         stall_cnt <= 2'd0;
      end else if (taken) begin
         dout      <= mem[taken_addr[15:0]];
         stall_cnt <= taken_stall;
         ready     <= taken_stall == 2'd0;
      end else if (stall_cnt != 2'd0) begin
         stall_cnt <= stall_cnt - 2'd1;
         ready     <= stall_cnt == 2'd1;
      end
   end

endmodule

// ==== verification/memory_upload_tb.sv ====
`timescale 1ns/1ps

module memory_upload_tb
   import msx_types_pkg::*;
   import upload_pkg::*;
();

   typedef struct packed {
      logic [ram_addr_w-1:0] addr;
      logic [7:0]            data;
   } ram_wr_t;

   localparam int upload_timeout = 400000;
   localparam int block_bytes    = 1 << block_shift;

   logic                    clk;
   logic                    rst_n;
   logic                    ioctl_download;
   logic [15:0]             ioctl_index;
   logic [ioctl_addr_w-1:0] ioctl_addr;
   logic                    reset_rq;
   logic [ddr_addr_w-1:0]   ddr3_addr;
   logic                    ddr3_rd;
   logic                    ddr3_request;
   logic [7:0]              ddr3_dout;
   logic                    ddr3_ready;
   logic [1:0]              ddr3_stall;
   logic [ram_addr_w-1:0]   ram_addr;
   logic [7:0]              ram_din;
   logic                    ram_ce;
   logic                    ram_rq;
   logic                    ram_ready;
   slot_entry_t             slot_layout [64];
   lookup_ram_t             lookup_ram [16];
   bios_config_t            bios_config;

   logic [31:0] rng;
   ram_wr_t     wr_log [$];
   int          errors;
   int          tests;
   bit          timed_out;
   string       test_name;

   memory_upload dut0 (
      .clk, .rst_n, .ioctl_download, .ioctl_index, .ioctl_addr, .reset_rq,
      .ddr3_addr, .ddr3_rd, .ddr3_request, .ddr3_dout, .ddr3_ready,
      .ram_addr, .ram_din, .ram_ce, .ram_rq, .ram_ready,
      .slot_layout, .lookup_ram, .bios_config
   );

   ddr3_model ddr0 (
      .clk, .rst_n, .addr(ddr3_addr), .rd(ddr3_rd), .stall(ddr3_stall),
      .dout(ddr3_dout), .ready(ddr3_ready)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Background DDR3 content
   function automatic logic [7:0] fill_byte(input logic [27:0] a);
      return a[7:0] ^ {a[12:8], a[15:13]} ^ a[23:16] ^ {4'h9, a[27:24]};
   endfunction

   function automatic logic [7:0] stripe_byte(input logic [26:0] a);
      return (a[8] == a[1]) ? 8'hff : 8'h00;
   endfunction

   function automatic slot_entry_t make_entry(input mapper_t m, input device_t d,
                                              input logic [3:0] r, input logic [1:0] o);
      slot_entry_t e;
      e.mapper     = m;
      e.device     = d;
      e.ref_ram    = r;
      e.offset_ram = o;
      return e;
   endfunction

   always @(negedge clk) begin
      rng        = lcg_next(rng);
      ram_ready  = rng[17:16] != 2'd0;      // Low about one cycle in four
      ddr3_stall = rng[21:20];
   end

   // RAM sink
   always @(posedge clk) begin
      if (rst_n && ram_ce) begin
         if (!ram_rq || !reset_rq) begin
            $display("RAM write at address %h happened outside a block load", ram_addr);
            errors = errors + 1;
         end
         wr_log.push_back({ram_addr, ram_din});
      end
   end

   always @(posedge clk) begin
      if (rst_n && ddr3_rd && !ddr3_request) begin
         $display("DDR3 read at address %h issued while ddr3_request was low", ddr3_addr);
         errors = errors + 1;
      end
   end

   task automatic mismatch(input string what, input logic [63:0] expected,
                           input logic [63:0] actual);
      $display("CHECK FAILED %s: %s expected %0h actual %0h", test_name, what, expected, actual);
      errors = errors + 1;
   endtask

   task automatic apply_reset();
      @(negedge clk);
      rst_n = 1'b0;
      repeat (10) @(negedge clk);
      rst_n = 1'b1;
   endtask

   task automatic fill_ddr();
      for (int i = 0; i < 65536; i++) begin
         ddr0.mem[i] = fill_byte(28'(i));
      end
   endtask

   task automatic put_header(input int base, input logic [7:0] typ_sub, input logic [7:0] id,
                             input logic [15:0] size, input logic [7:0] dev,
                             input logic [7:0] mapper, input logic [7:0] mode,
                             input logic [7:0] param);
      logic [7:0] hdr [16];
      hdr = '{8'h4d, 8'h53, 8'h58, typ_sub, id, size[15:8], size[7:0], dev, mapper, mode,
              param, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
      for (int i = 0; i < 16; i++) begin
         ddr0.mem[base + i] = hdr[i];
      end
   endtask

   task automatic run_upload(input int size);
      int n;
      wr_log.delete();
      @(negedge clk);
      ioctl_index    = 16'(config_index);
      ioctl_addr     = ioctl_addr_w'(size);
      ioctl_download = 1'b1;
      repeat (3) @(negedge clk);
      ioctl_download = 1'b0;
      n = 0;
      while (!reset_rq && n < 20) begin
         @(negedge clk);
         n++;
      end
      if (!reset_rq) begin
         $display("Timeout in %s: reset_rq never rose after the download", test_name);
         errors    = errors + 1;
         timed_out = 1'b1;
      end else begin
         n = 0;
         while (reset_rq && n < upload_timeout) begin
            @(negedge clk);
            n++;
         end
         if (reset_rq) begin
            $display("Timeout in %s: the upload never finished", test_name);
            errors    = errors + 1;
            timed_out = 1'b1;
         end
      end
   endtask

   // Subslot sub must hold exp_row and every other entry must be empty
   task automatic check_layout(input int sub, input slot_row_t exp_row);
      slot_entry_t exp;
      slot_entry_t empty;
      empty = make_entry(mapper_unused, device_none, 4'd0, 2'd0);
      for (int i = 0; i < 64; i++) begin
         exp = (i / 4 == sub) ? exp_row[i % 4] : empty;
         if (slot_layout[i] !== exp) mismatch($sformatf("slot_layout[%0d]", i), exp, slot_layout[i]);
      end
   endtask

   task automatic check_block(input int first, input int count, input bit pattern, input int src);
      logic [7:0] exp;
      for (int i = 0; i < count; i++) begin
         exp = pattern ? stripe_byte(27'(first + i)) : fill_byte(28'(src + i));
         if (wr_log[first + i].addr !== 27'(first + i)) begin
            mismatch("RAM write address", first + i, wr_log[first + i].addr);
            break;
         end
         if (wr_log[first + i].data !== exp) begin
            mismatch($sformatf("RAM byte %0h", first + i), exp, wr_log[first + i].data);
            break;
         end
      end
   endtask

   task automatic reset_state();
      test_name = "reset_state";
      tests++;
      apply_reset();
      if (reset_rq !== 1'b0) mismatch("reset_rq", 0, reset_rq);
      if (ram_ce !== 1'b0) mismatch("ram_ce", 0, ram_ce);
      if (ddr3_rd !== 1'b0) mismatch("ddr3_rd", 0, ddr3_rd);
      if (ddr3_request !== 1'b0) mismatch("ddr3_request", 0, ddr3_request);
      if (ram_rq !== 1'b0) mismatch("ram_rq", 0, ram_rq);
      check_layout(-1, '0);
   endtask

   task automatic rom_copy();
      slot_row_t exp_row;
      test_name = "rom_copy";
      tests++;
      apply_reset();
      fill_ddr();
      put_header(0, {cfg_slot_internal, 4'd5}, rom_rom, 16'd1, device_scc, mapper_konami,
                 8'h02, 8'h01);
      run_upload(header_len + block_bytes);
      if (wr_log.size() != block_bytes) mismatch("RAM write count", block_bytes, wr_log.size());
      else check_block(0, block_bytes, 1'b0, header_len);
      if (lookup_ram[0] !== {27'd0, 16'd1, 1'b1}) mismatch("lookup_ram[0]",
         {27'd0, 16'd1, 1'b1}, lookup_ram[0]);
      exp_row    = {4{make_entry(mapper_unused, device_none, 4'd0, 2'd0)}};
      exp_row[0] = make_entry(mapper_konami, device_scc, 4'd0, 2'd1);
      check_layout(5, exp_row);
   endtask

   task automatic ram_pattern();
      slot_row_t exp_row;
      test_name = "ram_pattern";
      tests++;
      apply_reset();
      fill_ddr();
      put_header(0, {cfg_slot_internal, 4'd5}, rom_rom, 16'd1, device_scc, mapper_konami,
                 8'h02, 8'h01);
      put_header(header_len + block_bytes, {cfg_slot_internal, 4'd5}, rom_ram, 16'd1,
                 device_fm_pac, mapper_ram, 8'h1c, 8'h08);    // Page 1 mode 3, page 2 mode 1
      run_upload(2 * header_len + block_bytes);
      if (wr_log.size() != 2 * block_bytes) begin
         mismatch("RAM write count", 2 * block_bytes, wr_log.size());
      end else begin
         check_block(0, block_bytes, 1'b0, header_len);
         check_block(block_bytes, block_bytes, 1'b1, 0);
      end
      if (lookup_ram[1] !== {27'(block_bytes), 16'd1, 1'b0}) mismatch("lookup_ram[1]",
         {27'(block_bytes), 16'd1, 1'b0}, lookup_ram[1]);
      exp_row    = {4{make_entry(mapper_unused, device_none, 4'd0, 2'd0)}};
      exp_row[0] = make_entry(mapper_konami, device_scc, 4'd0, 2'd1);
      exp_row[1] = make_entry(mapper_unused, device_fm_pac, 4'd1, 2'd2);
      exp_row[2] = make_entry(mapper_konami, device_none, 4'd0, 2'd1);   // Copy of page 0
      check_layout(5, exp_row);
   endtask

   task automatic bad_magic();
      test_name = "bad_magic";
      tests++;
      fill_ddr();
      put_header(0, {cfg_slot_internal, 4'd5}, rom_rom, 16'd1, device_scc, mapper_konami,
                 8'h02, 8'h01);
      ddr0.mem[2] = 8'h59;                                    // MSY
      run_upload(header_len + block_bytes);
      if (wr_log.size() != 0) mismatch("RAM write count", 0, wr_log.size());
      if (ddr3_addr !== 28'(header_len)) mismatch("ddr3_addr at end", header_len, ddr3_addr);
      check_layout(-1, '0);
   endtask

   task automatic config_skip();
      test_name = "config_skip";
      tests++;
      fill_ddr();
      put_header(0, {cfg_config, 4'd0}, 8'h25, 16'd0, 8'd0, 8'd0, 8'd0, 8'd0);
      put_header(16, {cfg_kbd_layout, 4'd0}, 8'd0, 16'd0, 8'd0, 8'd0, 8'd0, 8'd0);
      put_header(32 + kbd_body_len, {cfg_config, 4'd0}, 8'h1a, 16'd0, 8'd0, 8'd0, 8'd0, 8'd0);
      run_upload(48 + kbd_body_len);
      if (bios_config !== {4'ha, 2'd1}) mismatch("bios_config", {4'ha, 2'd1}, bios_config);
      if (ddr3_addr !== 28'(48 + kbd_body_len)) mismatch("ddr3_addr at end",
         48 + kbd_body_len, ddr3_addr);
      if (wr_log.size() != 0) mismatch("RAM write count", 0, wr_log.size());
   endtask

   initial begin
      rst_n          = 1'b0;
      ioctl_download = 1'b0;
      ioctl_index    = 16'd0;
      ioctl_addr     = '0;
      ram_ready      = 1'b1;
      ddr3_stall     = 2'd0;
      rng            = 32'h2bae;
      errors         = 0;
      tests          = 0;
      timed_out      = 1'b0;
      reset_state();
      if (!timed_out) rom_copy();
      if (!timed_out) ram_pattern();
      if (!timed_out) bad_magic();                         // Table is full from the last test
      if (!timed_out) config_skip();
      $display("%0d tests run, %0d errors", tests, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

// ==== files.f ====
hw/msx_types_pkg.sv
hw/upload_pkg.sv
hw/page_entry_builder.sv
hw/slot_table.sv
hw/block_loader.sv
hw/record_sequencer.sv
hw/memory_upload.sv
verification/ddr3_model.sv
verification/memory_upload_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module memory_upload_tb \
   -f files.f -o sim_memory_upload
./obj_dir/sim_memory_upload > sim.log 2>&1 || true
cat sim.log
if grep -qx '>>> PASS' sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
